// File: xbar_pkg.sv
// Fixed address map of three windows; the windows must not overlap and no access may fall outside them
package xbar_pkg;

	localparam int NUM_MASTERS = 2;
	localparam int NUM_SLAVES = 3;
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int PROT_W = 3;
	localparam int STRB_W = DATA_W / 8;
	localparam int MASTER_IDX_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;
	localparam int SLAVE_IDX_W = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [PROT_W-1:0] prot_t;
	typedef logic [STRB_W-1:0] strb_t;
	typedef logic [MASTER_IDX_W-1:0] master_idx_t;
	typedef logic [SLAVE_IDX_W-1:0] slave_idx_t;

	// Mask bits are the offset inside a window, base is the window start
	localparam addr_t SLAVE_MASK [NUM_SLAVES] = '{32'h0000_03FF, 32'h0000_001F, 32'h0000_0000};
	localparam addr_t SLAVE_BASE [NUM_SLAVES] = '{32'h0000_0000, 32'h0000_0400, 32'h0400_0000};

	typedef struct packed {
		logic  valid;
		addr_t addr;
		prot_t prot;
	} aw_req_t;

	typedef struct packed {
		logic  valid;
		data_t data;
		strb_t strb;
	} w_req_t;

	typedef struct packed {
		logic  valid;
		addr_t addr;
		prot_t prot;
	} ar_req_t;

	typedef struct packed {
		logic  valid;
		data_t data;
	} r_rsp_t;

	typedef enum logic {
		ARB_IDLE,
		ARB_BUSY
	} arb_state_e;

	// One bit per window that the address falls in
	function automatic logic [NUM_SLAVES-1:0] slave_hits(input addr_t addr);
		logic [NUM_SLAVES-1:0] hits;
		for (int s = 0; s < NUM_SLAVES; s++) begin
			hits[s] = ((addr & ~SLAVE_MASK[s]) == SLAVE_BASE[s]);
		end
		return hits;
	endfunction

	// Lowest matching window wins
	function automatic slave_idx_t decode_slave(input addr_t addr);
		logic [NUM_SLAVES-1:0] hits;
		slave_idx_t idx;
		hits = slave_hits(addr);
		idx = '0;
		for (int s = NUM_SLAVES - 1; s >= 0; s--) begin
			if (hits[s]) begin
				idx = slave_idx_t'(s);
			end
		end
		return idx;
	endfunction

endpackage

// File: channel_arbiter.sv
// One grant at a time per channel; a master that keeps requesting can win again, there is no fairness limit
module channel_arbiter
	import xbar_pkg::*;
(
	input  logic                   CLK,
	input  logic                   RST,
	input  logic [NUM_MASTERS-1:0] req_i,
	input  logic                   done_i,
	output master_idx_t            grant_idx_o,
	output logic                   busy_o,
	output logic                   start_o
);

	arb_state_e  state_q;
	master_idx_t ptr_q; // Round-robin pointer

	// Grant starts on the idle cycle the pointed-to master asks
	assign start_o = (state_q == ARB_IDLE) && req_i[ptr_q];
	assign busy_o = (state_q == ARB_BUSY);
	assign grant_idx_o = ptr_q; // Frozen while busy, so it names the owner

	always_ff @(posedge CLK) begin
		if (!RST) begin
			state_q <= ARB_IDLE;
			ptr_q <= '0;
		end else begin
			case (state_q)
				ARB_IDLE: begin
					if (start_o) begin
						state_q <= ARB_BUSY;
					end else if (ptr_q == master_idx_t'(NUM_MASTERS - 1)) begin
						ptr_q <= '0; // Wrap
					end else begin
						ptr_q <= ptr_q + 1'b1;
					end
				end
				ARB_BUSY: begin
					if (done_i) begin
						state_q <= ARB_IDLE; // Response handshake seen
					end
				end
				default: begin
					state_q <= ARB_IDLE;
				end
			endcase
		end
	end

	// Router may only complete a transaction that this arbiter granted
	assert property (@(posedge CLK) disable iff (!RST)
		(state_q == ARB_IDLE) |-> !done_i)
		else $error("done seen while arbiter idle");

endmodule

// File: write_router.sv
// Steers one write at a time; AW must stay valid until accepted, W may come with it or later
module write_router
	import xbar_pkg::*;
(
	input  logic                       CLK,
	input  logic                       RST,
	input  master_idx_t                grant_idx_i,
	input  logic                       busy_i,
	input  logic                       start_i,
	input  aw_req_t [NUM_MASTERS-1:0]  m_aw_i,
	input  w_req_t  [NUM_MASTERS-1:0]  m_w_i,
	input  logic    [NUM_MASTERS-1:0]  m_bready_i,
	output logic    [NUM_MASTERS-1:0]  m_awready_o,
	output logic    [NUM_MASTERS-1:0]  m_wready_o,
	output logic    [NUM_MASTERS-1:0]  m_bvalid_o,
	output aw_req_t [NUM_SLAVES-1:0]   s_aw_o,
	output w_req_t  [NUM_SLAVES-1:0]   s_w_o,
	output logic    [NUM_SLAVES-1:0]   s_bready_o,
	input  logic    [NUM_SLAVES-1:0]   s_awready_i,
	input  logic    [NUM_SLAVES-1:0]   s_wready_i,
	input  logic    [NUM_SLAVES-1:0]   s_bvalid_i,
	output logic                       done_o
);

	addr_t                  awaddr_q;  // Captured at grant
	slave_idx_t             slave_sel;
	logic [NUM_SLAVES-1:0]  s_en;      // One-hot, zero while idle
	logic [NUM_MASTERS-1:0] m_en;
	logic [NUM_SLAVES-1:0]  s_awvalid;
	aw_req_t                aw_req;    // Granted master's channels
	w_req_t                 w_req;
	logic                   bready;

	always_ff @(posedge CLK) begin
		if (start_i) begin
			awaddr_q <= m_aw_i[grant_idx_i].addr;
		end
	end

	assign slave_sel = decode_slave(awaddr_q);
	assign s_en = busy_i ? (NUM_SLAVES'(1) << slave_sel) : '0;
	assign m_en = busy_i ? (NUM_MASTERS'(1) << grant_idx_i) : '0;

	assign aw_req = m_aw_i[grant_idx_i];
	assign w_req = m_w_i[grant_idx_i];
	assign bready = m_bready_i[grant_idx_i];
	assign s_awvalid = s_en & {NUM_SLAVES{aw_req.valid}};

	// Payload is broadcast, only handshakes are steered
	always_comb begin
		for (int s = 0; s < NUM_SLAVES; s++) begin
			s_aw_o[s].valid = s_awvalid[s];
			s_aw_o[s].addr = aw_req.addr;
			s_aw_o[s].prot = aw_req.prot;
			s_w_o[s].valid = s_en[s] & w_req.valid;
			s_w_o[s].data = w_req.data;
			s_w_o[s].strb = w_req.strb;
			s_bready_o[s] = s_en[s] & bready;
		end
	end

	// Slave replies go back to the owner only
	always_comb begin
		for (int m = 0; m < NUM_MASTERS; m++) begin
			m_awready_o[m] = m_en[m] & s_awready_i[slave_sel];
			m_wready_o[m] = m_en[m] & s_wready_i[slave_sel];
			m_bvalid_o[m] = m_en[m] & s_bvalid_i[slave_sel];
		end
	end

	assign done_o = busy_i & s_bvalid_i[slave_sel] & bready; // B handshake ends the grant

	// Address held by the master at grant must land in exactly one window
	assert property (@(posedge CLK) disable iff (!RST)
		start_i |=> $onehot(slave_hits(awaddr_q)))
		else $error("write address %h outside the map or in overlapping windows", awaddr_q);

endmodule

// File: read_router.sv
// Steers one read at a time; AR must stay valid until accepted, R data reaches only the owner
module read_router
	import xbar_pkg::*;
(
	input  logic                       CLK,
	input  logic                       RST,
	input  master_idx_t                grant_idx_i,
	input  logic                       busy_i,
	input  logic                       start_i,
	input  ar_req_t [NUM_MASTERS-1:0]  m_ar_i,
	input  logic    [NUM_MASTERS-1:0]  m_rready_i,
	output logic    [NUM_MASTERS-1:0]  m_arready_o,
	output r_rsp_t  [NUM_MASTERS-1:0]  m_r_o,
	output ar_req_t [NUM_SLAVES-1:0]   s_ar_o,
	output logic    [NUM_SLAVES-1:0]   s_rready_o,
	input  logic    [NUM_SLAVES-1:0]   s_arready_i,
	input  r_rsp_t  [NUM_SLAVES-1:0]   s_r_i,
	output logic                       done_o
);

	addr_t                  araddr_q;  // Captured at grant
	slave_idx_t             slave_sel;
	logic [NUM_SLAVES-1:0]  s_en;
	logic [NUM_MASTERS-1:0] m_en;
	ar_req_t                ar_req;
	r_rsp_t                 r_rsp;     // Decoded slave's response
	logic                   rready;

	always_ff @(posedge CLK) begin
		if (start_i) begin
			araddr_q <= m_ar_i[grant_idx_i].addr;
		end
	end

	assign slave_sel = decode_slave(araddr_q);
	assign s_en = busy_i ? (NUM_SLAVES'(1) << slave_sel) : '0;
	assign m_en = busy_i ? (NUM_MASTERS'(1) << grant_idx_i) : '0;

	assign ar_req = m_ar_i[grant_idx_i];
	assign r_rsp = s_r_i[slave_sel];
	assign rready = m_rready_i[grant_idx_i];

	always_comb begin
		for (int s = 0; s < NUM_SLAVES; s++) begin
			s_ar_o[s].valid = s_en[s] & ar_req.valid;
			s_ar_o[s].addr = ar_req.addr; // Broadcast
			s_ar_o[s].prot = ar_req.prot;
			s_rready_o[s] = s_en[s] & rready;
		end
	end

	// Other masters read zero data
	always_comb begin
		for (int m = 0; m < NUM_MASTERS; m++) begin
			m_arready_o[m] = m_en[m] & s_arready_i[slave_sel];
			m_r_o[m].valid = m_en[m] & r_rsp.valid;
			m_r_o[m].data = m_en[m] ? r_rsp.data : '0;
		end
	end

	assign done_o = busy_i & r_rsp.valid & rready;

	// No error response exists, so a stray address must never be granted
	assert property (@(posedge CLK) disable iff (!RST)
		start_i |=> $onehot(slave_hits(araddr_q)))
		else $error("read address %h outside the map or in overlapping windows", araddr_q);

endmodule

// File: axi_lite_xbar.sv
// AXI4-lite 2x3 crossbar, one write and one read in flight at a time; unmapped addresses get no response
module axi_lite_xbar
	import xbar_pkg::*;
(
	input  logic                       CLK,
	input  logic                       RST,

	// Master side
	input  aw_req_t [NUM_MASTERS-1:0]  m_aw_i,
	input  w_req_t  [NUM_MASTERS-1:0]  m_w_i,
	input  ar_req_t [NUM_MASTERS-1:0]  m_ar_i,
	input  logic    [NUM_MASTERS-1:0]  m_bready_i,
	input  logic    [NUM_MASTERS-1:0]  m_rready_i,
	output logic    [NUM_MASTERS-1:0]  m_awready_o,
	output logic    [NUM_MASTERS-1:0]  m_wready_o,
	output logic    [NUM_MASTERS-1:0]  m_bvalid_o,
	output logic    [NUM_MASTERS-1:0]  m_arready_o,
	output r_rsp_t  [NUM_MASTERS-1:0]  m_r_o,

	// Slave side
	output aw_req_t [NUM_SLAVES-1:0]   s_aw_o,
	output w_req_t  [NUM_SLAVES-1:0]   s_w_o,
	output ar_req_t [NUM_SLAVES-1:0]   s_ar_o,
	output logic    [NUM_SLAVES-1:0]   s_bready_o,
	output logic    [NUM_SLAVES-1:0]   s_rready_o,
	input  logic    [NUM_SLAVES-1:0]   s_awready_i,
	input  logic    [NUM_SLAVES-1:0]   s_wready_i,
	input  logic    [NUM_SLAVES-1:0]   s_bvalid_i,
	input  logic    [NUM_SLAVES-1:0]   s_arready_i,
	input  r_rsp_t  [NUM_SLAVES-1:0]   s_r_i
);

	logic [NUM_MASTERS-1:0] aw_req_vec; // awvalid alone requests a write
	logic [NUM_MASTERS-1:0] ar_req_vec;
	master_idx_t            w_grant;
	master_idx_t            r_grant;
	logic                   w_busy;
	logic                   w_start;
	logic                   w_done;
	logic                   r_busy;
	logic                   r_start;
	logic                   r_done;

	for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_req
		assign aw_req_vec[m] = m_aw_i[m].valid;
		assign ar_req_vec[m] = m_ar_i[m].valid;
	end

	channel_arbiter u_warb (
		.CLK         (CLK),
		.RST         (RST),
		.req_i       (aw_req_vec),
		.done_i      (w_done),
		.grant_idx_o (w_grant),
		.busy_o      (w_busy),
		.start_o     (w_start)
	);

	channel_arbiter u_rarb (
		.CLK         (CLK),
		.RST         (RST),
		.req_i       (ar_req_vec),
		.done_i      (r_done),
		.grant_idx_o (r_grant),
		.busy_o      (r_busy),
		.start_o     (r_start)
	);

	write_router u_wrtr (
		.CLK         (CLK),
		.RST         (RST),
		.grant_idx_i (w_grant),
		.busy_i      (w_busy),
		.start_i     (w_start),
		.m_aw_i      (m_aw_i),
		.m_w_i       (m_w_i),
		.m_bready_i  (m_bready_i),
		.m_awready_o (m_awready_o),
		.m_wready_o  (m_wready_o),
		.m_bvalid_o  (m_bvalid_o),
		.s_aw_o      (s_aw_o),
		.s_w_o       (s_w_o),
		.s_bready_o  (s_bready_o),
		.s_awready_i (s_awready_i),
		.s_wready_i  (s_wready_i),
		.s_bvalid_i  (s_bvalid_i),
		.done_o      (w_done)
	);

	read_router u_rrtr (
		.CLK         (CLK),
		.RST         (RST),
		.grant_idx_i (r_grant),
		.busy_i      (r_busy),
		.start_i     (r_start),
		.m_ar_i      (m_ar_i),
		.m_rready_i  (m_rready_i),
		.m_arready_o (m_arready_o),
		.m_r_o       (m_r_o),
		.s_ar_o      (s_ar_o),
		.s_rready_o  (s_rready_o),
		.s_arready_i (s_arready_i),
		.s_r_i       (s_r_i),
		.done_o      (r_done)
	);

endmodule

// File: tb_axi_lite_xbar.sv
// Run from the project root so that xbar_golden.txt is found; paired golden lines must not share a master on one channel
module tb_axi_lite_xbar
	import xbar_pkg::*;
();

	localparam int NUM_LINES = 23;
	localparam int FIELDS = 7; // Words per golden line
	localparam int TIMEOUT_CYCLES = NUM_LINES * 64 + 20;

	logic CLK = 1'b0;
	logic RST;
	aw_req_t [NUM_MASTERS-1:0] m_aw;
	w_req_t  [NUM_MASTERS-1:0] m_w;
	ar_req_t [NUM_MASTERS-1:0] m_ar;
	logic    [NUM_MASTERS-1:0] m_bready;
	logic    [NUM_MASTERS-1:0] m_rready;
	logic    [NUM_MASTERS-1:0] m_awready, m_wready, m_bvalid, m_arready, m_rvalid_vec;
	r_rsp_t  [NUM_MASTERS-1:0] m_r;
	aw_req_t [NUM_SLAVES-1:0]  s_aw;
	w_req_t  [NUM_SLAVES-1:0]  s_w;
	ar_req_t [NUM_SLAVES-1:0]  s_ar;
	logic    [NUM_SLAVES-1:0]  s_bready, s_rready;
	logic    [NUM_SLAVES-1:0]  s_awvalid_vec, s_wvalid_vec, s_arvalid_vec;
	logic    [NUM_SLAVES-1:0]  s_awready = '0; // Slave model outputs
	logic    [NUM_SLAVES-1:0]  s_bvalid = '0;
	logic    [NUM_SLAVES-1:0]  s_arready = '0;
	r_rsp_t  [NUM_SLAVES-1:0]  s_r = '0;
	logic    [NUM_SLAVES-1:0]  awready_n, bvalid_n, arready_n;
	r_rsp_t  [NUM_SLAVES-1:0]  r_n;

	data_t golden [NUM_LINES*FIELDS];
	data_t mem [NUM_SLAVES][256];
	logic [31:0] rng_state = 32'd14171;
	int checks = 0;
	int errors = 0;
	int mon_errors = 0; // From the protocol monitor
	int cycles = 0;

	axi_lite_xbar i_axi_lite_xbar (
		.CLK(CLK), .RST(RST),
		.m_aw_i(m_aw), .m_w_i(m_w), .m_ar_i(m_ar), .m_bready_i(m_bready), .m_rready_i(m_rready),
		.m_awready_o(m_awready), .m_wready_o(m_wready), .m_bvalid_o(m_bvalid),
		.m_arready_o(m_arready), .m_r_o(m_r),
		.s_aw_o(s_aw), .s_w_o(s_w), .s_ar_o(s_ar), .s_bready_o(s_bready), .s_rready_o(s_rready),
		.s_awready_i(s_awready), .s_wready_i(s_awready), .s_bvalid_i(s_bvalid),
		.s_arready_i(s_arready), .s_r_i(s_r)
	);

	always #5 CLK = ~CLK;

	always_comb begin
		for (int s = 0; s < NUM_SLAVES; s++) begin
			s_awvalid_vec[s] = s_aw[s].valid;
			s_wvalid_vec[s] = s_w[s].valid;
			s_arvalid_vec[s] = s_ar[s].valid;
		end
		for (int m = 0; m < NUM_MASTERS; m++) begin
			m_rvalid_vec[m] = m_r[m].valid;
		end
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: transactions still pending after %0d cycles", cycles);
			$display("Checks: %0d, errors: %0d, protocol errors: %0d", checks, errors, mon_errors);
			$display("Simulation failed");
			$finish;
		end
	end

	// At most one valid per channel on each side
	always @(negedge CLK) begin
		if (RST) begin
			assert ($onehot0(s_awvalid_vec)) else begin
				mon_errors++;
				$display("Two slaves saw awvalid in the same cycle");
			end
			assert ($onehot0(s_wvalid_vec)) else begin
				mon_errors++;
				$display("Two slaves saw wvalid in the same cycle");
			end
			assert ($onehot0(s_arvalid_vec)) else begin
				mon_errors++;
				$display("Two slaves saw arvalid in the same cycle");
			end
			assert ($onehot0(m_bvalid) && $onehot0(m_rvalid_vec)) else begin
				mon_errors++;
				$display("A response reached both masters in the same cycle");
			end
		end
	end

	// Three memories; AW and W are taken together, B and R follow a cycle later
	initial begin
		for (int s = 0; s < NUM_SLAVES; s++) begin
			for (int k = 0; k < 256; k++) begin
				mem[s][k] = (SLAVE_BASE[s] | addr_t'(k << 2)) ^ 32'h5A5A_5A5A;
			end
		end
		forever begin
			@(negedge CLK);
			awready_n = s_awready;
			bvalid_n = s_bvalid;
			arready_n = s_arready;
			r_n = s_r;
			for (int s = 0; s < NUM_SLAVES; s++) begin
				if (s_awready[s] && s_aw[s].valid && s_w[s].valid) begin
					for (int b = 0; b < STRB_W; b++) begin
						if (s_w[s].strb[b]) begin
							mem[s][s_aw[s].addr[9:2]][8*b +: 8] = s_w[s].data[8*b +: 8];
						end
					end
					awready_n[s] = 1'b0;
					bvalid_n[s] = 1'b1;
				end else if (!s_awready[s] && !s_bvalid[s] && s_aw[s].valid && s_w[s].valid) begin
					awready_n[s] = 1'b1;
				end else if (s_bvalid[s] && s_bready[s]) begin
					bvalid_n[s] = 1'b0;
				end
				if (s_arready[s] && s_ar[s].valid) begin
					arready_n[s] = 1'b0;
					r_n[s] = '{1'b1, mem[s][s_ar[s].addr[9:2]]};
				end else if (!s_arready[s] && !s_r[s].valid && s_ar[s].valid) begin
					arready_n[s] = 1'b1;
				end else if (s_r[s].valid && s_rready[s]) begin
					r_n[s].valid = 1'b0;
				end
			end
			@(posedge CLK);
			#1;
			s_awready = awready_n;
			s_bvalid = bvalid_n;
			s_arready = arready_n;
			s_r = r_n;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic write_and_check(input int line, input master_idx_t m, input addr_t addr,
			input data_t data, input strb_t strb, input slave_idx_t exp_s);
		string name;
		prot_t prot;
		logic aw_done;
		logic w_done;
		int hold;
		name = $sformatf("line %0d write", line);
		prot = prot_t'(line);
		aw_done = 1'b0;
		w_done = 1'b0;
		@(posedge CLK);
		#1;
		m_aw[m] = '{1'b1, addr, prot};
		m_w[m] = '{1'b1, data, strb};
		while (!(aw_done && w_done)) begin
			@(negedge CLK);
			if (!aw_done && m_awready[m]) begin
				aw_done = 1'b1;
				check_value({name, " aw slave"}, 32'(1) << exp_s, 32'(s_awvalid_vec & s_awready));
				check_value({name, " aw addr"}, addr, s_aw[exp_s].addr);
				check_value({name, " aw prot"}, 32'(prot), 32'(s_aw[exp_s].prot));
			end
			if (!w_done && m_wready[m]) begin
				w_done = 1'b1;
				check_value({name, " w slave"}, 32'(1) << exp_s, 32'(s_wvalid_vec & s_awready));
				check_value({name, " w data"}, data, s_w[exp_s].data);
				check_value({name, " w strb"}, 32'(strb), 32'(s_w[exp_s].strb));
			end
			@(posedge CLK);
			#1;
			m_aw[m].valid = !aw_done;
			m_w[m].valid = !w_done;
		end
		rng_state = xorshift32(rng_state);
		hold = int'(rng_state[2:0]); // bready low this long
		@(negedge CLK);
		while (!m_bvalid[m]) @(negedge CLK);
		repeat (hold) begin
			check_value({name, " bvalid held"}, 32'd1, 32'(m_bvalid[m]));
			check_value({name, " awvalid during hold"}, 32'd0, 32'(s_awvalid_vec));
			@(negedge CLK);
		end
		@(posedge CLK);
		#1;
		m_bready[m] = 1'b1;
		@(negedge CLK);
		check_value({name, " bvalid at handshake"}, 32'd1, 32'(m_bvalid[m]));
		check_value({name, " bready slave"}, 32'(1) << exp_s, 32'(s_bready));
		@(posedge CLK);
		#1;
		m_bready[m] = 1'b0;
	endtask

	task automatic read_and_check(input int line, input master_idx_t m, input addr_t addr,
			input slave_idx_t exp_s, input data_t exp_data);
		string name;
		prot_t prot;
		int hold;
		name = $sformatf("line %0d read", line);
		prot = prot_t'(line);
		@(posedge CLK);
		#1;
		m_ar[m] = '{1'b1, addr, prot};
		@(negedge CLK);
		while (!m_arready[m]) @(negedge CLK);
		check_value({name, " ar slave"}, 32'(1) << exp_s, 32'(s_arvalid_vec & s_arready));
		check_value({name, " ar addr"}, addr, s_ar[exp_s].addr);
		check_value({name, " ar prot"}, 32'(prot), 32'(s_ar[exp_s].prot));
		@(posedge CLK);
		#1;
		m_ar[m].valid = 1'b0;
		rng_state = xorshift32(rng_state);
		hold = int'(rng_state[2:0]);
		@(negedge CLK);
		while (!m_r[m].valid) @(negedge CLK);
		repeat (hold) begin
			check_value({name, " rvalid held"}, 32'd1, 32'(m_r[m].valid));
			check_value({name, " data held"}, exp_data, m_r[m].data);
			check_value({name, " arvalid during hold"}, 32'd0, 32'(s_arvalid_vec));
			@(negedge CLK);
		end
		@(posedge CLK);
		#1;
		m_rready[m] = 1'b1;
		@(negedge CLK);
		check_value({name, " rvalid at handshake"}, 32'd1, 32'(m_r[m].valid));
		check_value({name, " data"}, exp_data, m_r[m].data);
		check_value({name, " other master data"}, 32'd0, m_r[~m].data);
		check_value({name, " rready slave"}, 32'(1) << exp_s, 32'(s_rready));
		@(posedge CLK);
		#1;
		m_rready[m] = 1'b0;
	endtask

	task automatic run_line(input int idx);
		int base;
		base = idx * FIELDS;
		if (golden[base][0]) begin
			read_and_check(idx + 1, master_idx_t'(golden[base+1]), golden[base+2],
				slave_idx_t'(golden[base+5]), golden[base+6]);
		end else begin
			write_and_check(idx + 1, master_idx_t'(golden[base+1]), golden[base+2],
				golden[base+3], strb_t'(golden[base+4]), slave_idx_t'(golden[base+5]));
		end
	endtask

	initial begin
		int i;
		RST = 1'b0;
		m_aw = '0;
		m_w = '0;
		m_ar = '0;
		m_bready = '0;
		m_rready = '0;
		$readmemh("xbar_golden.txt", golden);
		repeat (10) @(posedge CLK);
		#1;
		RST = 1'b1;
		@(negedge CLK);
		check_value("reset master side", 32'd0,
			32'({m_awready, m_wready, m_bvalid, m_arready, m_rvalid_vec}));
		check_value("reset slave side", 32'd0,
			32'({s_awvalid_vec, s_wvalid_vec, s_arvalid_vec, s_bready, s_rready}));
		assert (!$isunknown(golden[NUM_LINES*FIELDS-1])) else begin
			errors++;
			$display("Golden file is missing or shorter than expected");
		end
		i = 0;
		while (errors == 0 && i < NUM_LINES) begin
			if (golden[i*FIELDS][1] && (i + 1 < NUM_LINES)) begin
				fork // Two transactions start on the same edge
					run_line(i);
					run_line(i + 1);
				join
				i = i + 2;
			end else begin
				run_line(i);
				i = i + 1;
			end
		end
		$display("Checks: %0d, errors: %0d, protocol errors: %0d", checks, errors, mon_errors);
		if (errors == 0 && mon_errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: xbar_golden.txt
// op (0 write, 1 read, +2 starts together with the next line) master addr data strb slave rdata
// Words never written read back as their byte address xor 5A5A5A5A
0 0 00000010 11223344 F 0 00000000
0 1 00000404 AABBCCDD F 1 00000000
0 0 04000000 CAFEF00D F 2 00000000
0 1 000003FC 01020304 F 0 00000000
1 1 00000010 00000000 0 0 11223344
1 0 00000404 00000000 0 1 AABBCCDD
1 1 04000000 00000000 0 2 CAFEF00D
0 0 00000010 EEEEEEEE 5 0 00000000
1 0 00000010 00000000 0 0 11EE33EE
2 0 00000100 12345678 F 0 00000000
0 1 00000418 87654321 F 1 00000000
3 0 00000100 00000000 0 0 12345678
1 1 00000418 00000000 0 1 87654321
2 1 00000404 FFFF0000 C 1 00000000
1 0 000003FC 00000000 0 0 01020304
3 0 00000020 00000000 0 0 5A5A5A7A
0 1 000003FC 00000099 1 0 00000000
1 1 00000404 00000000 0 1 FFFFCCDD
1 0 000003FC 00000000 0 0 01020399
2 0 00000200 DEADBEEF F 0 00000000
0 1 00000204 0BADC0DE F 0 00000000
3 0 00000204 00000000 0 0 0BADC0DE
1 1 00000200 00000000 0 0 DEADBEEF

// File: files.f
xbar_pkg.sv
channel_arbiter.sv
write_router.sv
read_router.sv
axi_lite_xbar.sv
tb_axi_lite_xbar.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_axi_lite_xbar
FLAGS ?=

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --assert --top-module $(TOP) $(FLAGS) -f files.f

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Simulation passed"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) $(FLAGS) -f files.f

clean:
	rm -rf obj_dir
